/* hw/cache_pkg.sv */
package cache_pkg;

    // word and line geometry
    localparam int WORD_BYTES     = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BYTES     = 16;
    localparam int WORD_BITS      = WORD_BYTES * 8;
    localparam int LINE_BITS      = LINE_BYTES * 8;

    // bank organisation
    localparam int NUM_LINES      = 16;
    localparam int LINE_SEL_BITS  = 4;
    localparam int CACHE_TAG_BITS = 4;
    localparam int LINE_ADDR_BITS = 8;
    localparam int WORD_SEL_BITS  = 2;
    localparam int REQ_TAG_BITS   = 4;

    // queue sizes
    localparam int CRSQ_DEPTH     = 4;
    localparam int MREQ_DEPTH     = 4;

    // packed queue entries {tag, word} and {rw, addr, byteen, line}
    localparam int CRSQ_DATAW     = REQ_TAG_BITS + WORD_BITS;
    localparam int MREQ_DATAW     = 1 + LINE_ADDR_BITS + LINE_BYTES + LINE_BITS;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LINE_SEL_BITS-1:0]  line_sel_t;
    typedef logic [CACHE_TAG_BITS-1:0] cache_tag_t;
    typedef logic [WORD_SEL_BITS-1:0]  word_sel_t;
    typedef logic [WORD_BYTES-1:0]     byteen_t;
    typedef logic [LINE_BYTES-1:0]     line_byteen_t;
    typedef logic [REQ_TAG_BITS-1:0]   req_tag_t;

    typedef enum logic [1:0] {
        INIT,
        RUN,
        MISS_WAIT
    } bank_state_t;

endpackage

/* hw/tag_lookup_if.sv */
`timescale 1ns/1ps

interface tag_lookup_if;
    import cache_pkg::*;

    line_sel_t  line_sel;
    cache_tag_t lookup_tag;
    logic       hit;
    // one-cycle write strobes
    logic       fill;
    cache_tag_t fill_tag;
    logic       init;

    modport ctrl (
        output line_sel, lookup_tag, fill, fill_tag, init,
        input  hit
    );

    modport store (
        input  line_sel, lookup_tag, fill, fill_tag, init,
        output hit
    );
endinterface

/* hw/data_access_if.sv */
`timescale 1ns/1ps

interface data_access_if;
    import cache_pkg::*;

    line_sel_t line_sel;
    word_sel_t wsel;
    word_t     read_data;

    // byte-enabled word write on a write hit
    logic      write;
    byteen_t   byteen;
    word_t     write_data;

    // whole line from memory
    logic      fill;
    line_t     fill_data;

    modport ctrl (
        output line_sel, wsel, write, byteen, write_data, fill, fill_data,
        input  read_data
    );

    modport store (
        input  line_sel, wsel, write, byteen, write_data, fill, fill_data,
        output read_data
    );
endinterface

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATAW = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [DATAW-1:0] din,
    input  logic             pop,
    output logic [DATAW-1:0] dout,
    output logic             full,
    output logic             empty
);
    localparam int ADDRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW  = $clog2(DEPTH + 1);

    logic [DATAW-1:0] mem [DEPTH];
    logic [ADDRW-1:0] wr_ptr;
    logic [ADDRW-1:0] rd_ptr;
    logic [CNTW-1:0]  count;

    assign full  = (count == CNTW'(DEPTH));
    assign empty = (count == '0);
    // head entry shows without a pop
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ADDRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ADDRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        !(push && full) && !(pop && empty));

endmodule

/* hw/tag_store.sv */
`timescale 1ns/1ps

module tag_store (
    input  logic       clk,
    input  logic       reset,
    tag_lookup_if.store bus
);
    import cache_pkg::*;

    logic [NUM_LINES-1:0] valid;
    cache_tag_t           tags [NUM_LINES];

    // combinational lookup on the selected line
    assign bus.hit = valid[bus.line_sel] && (tags[bus.line_sel] == bus.lookup_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (bus.init) begin
            valid[bus.line_sel] <= 1'b0;
        end else if (bus.fill) begin
            valid[bus.line_sel] <= 1'b1;
        end
    end

    // tag written on fill only
    always_ff @(posedge clk) begin
        if (bus.fill) begin
            tags[bus.line_sel] <= bus.fill_tag;
        end
    end

    // sweep and miss handling never overlap
    a_fill_init_excl: assert property (@(posedge clk) disable iff (reset)
        !(bus.fill && bus.init));

endmodule

/* hw/data_store.sv */
`timescale 1ns/1ps

module data_store (
    input  logic         clk,
    data_access_if.store bus
);
    import cache_pkg::*;

    line_t lines [NUM_LINES];

    // selected word is always visible
    assign bus.read_data = lines[bus.line_sel][bus.wsel * WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk) begin
        if (bus.fill) begin
            lines[bus.line_sel] <= bus.fill_data;
        end else if (bus.write) begin
            // only the enabled bytes of the word
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (bus.byteen[b]) begin
                    lines[bus.line_sel][bus.wsel * WORD_BITS + b * 8 +: 8]
                        <= bus.write_data[b * 8 +: 8];
                end
            end
        end
    end

    // a fill only happens while the pipe waits on a read miss
    a_fill_write_excl: assert property (@(posedge clk)
        !(bus.fill && bus.write));

endmodule

/* hw/bank_ctrl.sv */
`timescale 1ns/1ps

module bank_ctrl (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              core_req_valid,
    input  logic                              core_req_rw,
    input  cache_pkg::line_addr_t             core_req_addr,
    input  cache_pkg::word_sel_t              core_req_wsel,
    input  cache_pkg::byteen_t                core_req_byteen,
    input  cache_pkg::word_t                  core_req_data,
    input  cache_pkg::req_tag_t               core_req_tag,
    output logic                              core_req_ready,

    input  logic                              mem_rsp_valid,
    input  cache_pkg::line_t                  mem_rsp_data,
    output logic                              mem_rsp_ready,

    tag_lookup_if.ctrl                        tags,
    data_access_if.ctrl                       data,

    output logic                              crsq_push,
    output logic [cache_pkg::CRSQ_DATAW-1:0]  crsq_din,
    input  logic                              crsq_full,
    output logic                              mreq_push,
    output logic [cache_pkg::MREQ_DATAW-1:0]  mreq_din,
    input  logic                              mreq_full
);
    import cache_pkg::*;

    bank_state_t  state;
    bank_state_t  state_n;
    line_sel_t    init_cnt;

    logic         valid_st0;
    logic         rw_st0;
    line_addr_t   addr_st0;
    word_sel_t    wsel_st0;
    byteen_t      byteen_st0;
    word_t        data_st0;
    req_tag_t     tag_st0;

    logic         valid_st1;
    logic         rw_st1;
    line_addr_t   addr_st1;
    word_sel_t    wsel_st1;
    byteen_t      byteen_st1;
    word_t        data_st1;
    req_tag_t     tag_st1;
    logic         hit_st1;

    logic         do_read_st1;
    logic         do_read_hit_st1;
    logic         do_read_miss_st1;
    logic         do_write_st1;
    logic         pipe_stall;
    logic         core_req_fire;
    logic         fill_fire;
    line_byteen_t wr_byteen;

    assign do_read_st1      = valid_st1 && !rw_st1;
    assign do_read_hit_st1  = do_read_st1 && hit_st1;
    assign do_read_miss_st1 = do_read_st1 && !hit_st1;
    assign do_write_st1     = valid_st1 && rw_st1;

    // a read miss holds stage 1 until its fill is in
    assign pipe_stall = (do_read_hit_st1 && crsq_full)
                     || ((do_read_miss_st1 || do_write_st1) && mreq_full)
                     || do_read_miss_st1
                     || (state == MISS_WAIT);

    assign core_req_ready = (state == RUN) && !pipe_stall;
    assign core_req_fire  = core_req_valid && core_req_ready;
    assign mem_rsp_ready  = (state == MISS_WAIT);
    assign fill_fire      = mem_rsp_valid && mem_rsp_ready;

    always_comb begin
        state_n = state;
        case (state)
            INIT:      if (init_cnt == line_sel_t'(NUM_LINES - 1)) state_n = RUN;
            RUN:       if (do_read_miss_st1 && !mreq_full) state_n = MISS_WAIT;
            MISS_WAIT: if (fill_fire) state_n = RUN;
            default:   state_n = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= INIT;
            init_cnt <= '0;
        end else begin
            state <= state_n;
            // one line cleared per cycle
            if (state == INIT) begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_st0 <= 1'b0;
            valid_st1 <= 1'b0;
        end else if (!pipe_stall) begin
            valid_st0 <= core_req_fire;
            valid_st1 <= valid_st0;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            rw_st0     <= core_req_rw;
            addr_st0   <= core_req_addr;
            wsel_st0   <= core_req_wsel;
            byteen_st0 <= core_req_byteen;
            data_st0   <= core_req_data;
            tag_st0    <= core_req_tag;
            rw_st1     <= rw_st0;
            addr_st1   <= addr_st0;
            wsel_st1   <= wsel_st0;
            byteen_st1 <= byteen_st0;
            data_st1   <= data_st0;
            tag_st1    <= tag_st0;
            hit_st1    <= tags.hit;
        end else if (fill_fire) begin
            // the waiting read replays as a hit
            hit_st1 <= 1'b1;
        end
    end

    // tag port shared by init sweep, fill and stage-0 lookup
    always_comb begin
        if (state == INIT) begin
            tags.line_sel = init_cnt;
        end else if (state == MISS_WAIT) begin
            tags.line_sel = addr_st1[LINE_SEL_BITS-1:0];
        end else begin
            tags.line_sel = addr_st0[LINE_SEL_BITS-1:0];
        end
    end
    assign tags.lookup_tag = addr_st0[LINE_ADDR_BITS-1 -: CACHE_TAG_BITS];
    assign tags.fill       = fill_fire;
    assign tags.fill_tag   = addr_st1[LINE_ADDR_BITS-1 -: CACHE_TAG_BITS];
    assign tags.init       = (state == INIT);

    // data store works on stage 1 only
    assign data.line_sel   = addr_st1[LINE_SEL_BITS-1:0];
    assign data.wsel       = wsel_st1;
    assign data.write      = do_write_st1 && hit_st1 && !mreq_full;
    assign data.byteen     = byteen_st1;
    assign data.write_data = data_st1;
    assign data.fill       = fill_fire;
    assign data.fill_data  = mem_rsp_data;

    assign crsq_push = do_read_hit_st1 && !crsq_full;
    assign crsq_din  = {tag_st1, data.read_data};

    // write-through byte enables land in the selected word slot
    assign wr_byteen = rw_st1 ? (line_byteen_t'(byteen_st1) << (wsel_st1 * WORD_BYTES)) : '0;

    assign mreq_push = ((do_read_miss_st1 && (state == RUN)) || do_write_st1) && !mreq_full;
    assign mreq_din  = {rw_st1, addr_st1, wr_byteen, {WORDS_PER_LINE{data_st1}}};

    // memory only answers the one outstanding line read
    a_fill_in_miss: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> state == MISS_WAIT);

    // the missing read stays parked in stage 1 until its fill
    a_miss_held_st1: assert property (@(posedge clk) disable iff (reset)
        state == MISS_WAIT |-> do_read_miss_st1);

endmodule

/* hw/cache_bank_top.sv */
`timescale 1ns/1ps

module cache_bank_top (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    core_req_valid,
    input  logic                    core_req_rw,
    input  cache_pkg::line_addr_t   core_req_addr,
    input  cache_pkg::word_sel_t    core_req_wsel,
    input  cache_pkg::byteen_t      core_req_byteen,
    input  cache_pkg::word_t        core_req_data,
    input  cache_pkg::req_tag_t     core_req_tag,
    output logic                    core_req_ready,

    output logic                    core_rsp_valid,
    output cache_pkg::word_t        core_rsp_data,
    output cache_pkg::req_tag_t     core_rsp_tag,
    input  logic                    core_rsp_ready,

    output logic                    mem_req_valid,
    output logic                    mem_req_rw,
    output cache_pkg::line_addr_t   mem_req_addr,
    output cache_pkg::line_byteen_t mem_req_byteen,
    output cache_pkg::line_t        mem_req_data,
    input  logic                    mem_req_ready,

    input  logic                    mem_rsp_valid,
    input  cache_pkg::line_t        mem_rsp_data,
    output logic                    mem_rsp_ready
);
    import cache_pkg::*;

    tag_lookup_if  tag_bus ();
    data_access_if data_bus ();

    logic                  crsq_push;
    logic [CRSQ_DATAW-1:0] crsq_din;
    logic                  crsq_full;
    logic                  crsq_empty;
    logic                  mreq_push;
    logic [MREQ_DATAW-1:0] mreq_din;
    logic                  mreq_full;
    logic                  mreq_empty;

    assign core_rsp_valid = !crsq_empty;
    assign mem_req_valid  = !mreq_empty;

    bank_ctrl i_ctrl (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready),
        .tags            (tag_bus.ctrl),
        .data            (data_bus.ctrl),
        .crsq_push       (crsq_push),
        .crsq_din        (crsq_din),
        .crsq_full       (crsq_full),
        .mreq_push       (mreq_push),
        .mreq_din        (mreq_din),
        .mreq_full       (mreq_full)
    );

    tag_store i_tags (
        .clk   (clk),
        .reset (reset),
        .bus   (tag_bus.store)
    );

    data_store i_data (
        .clk (clk),
        .bus (data_bus.store)
    );

    sync_fifo #(
        .DATAW (CRSQ_DATAW),
        .DEPTH (CRSQ_DEPTH)
    ) core_rsp_queue (
        .clk   (clk),
        .reset (reset),
        .push  (crsq_push),
        .din   (crsq_din),
        .pop   (core_rsp_valid && core_rsp_ready),
        .dout  ({core_rsp_tag, core_rsp_data}),
        .full  (crsq_full),
        .empty (crsq_empty)
    );

    sync_fifo #(
        .DATAW (MREQ_DATAW),
        .DEPTH (MREQ_DEPTH)
    ) mem_req_queue (
        .clk   (clk),
        .reset (reset),
        .push  (mreq_push),
        .din   (mreq_din),
        .pop   (mem_req_valid && mem_req_ready),
        .dout  ({mem_req_rw, mem_req_addr, mem_req_byteen, mem_req_data}),
        .full  (mreq_full),
        .empty (mreq_empty)
    );

endmodule

/* dv/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    core_req_valid,
    input  logic                    core_req_rw,
    input  cache_pkg::line_addr_t   core_req_addr,
    input  cache_pkg::word_sel_t    core_req_wsel,
    input  cache_pkg::byteen_t      core_req_byteen,
    input  cache_pkg::word_t        core_req_data,
    input  cache_pkg::req_tag_t     core_req_tag,
    input  logic                    core_req_ready,
    input  logic                    core_rsp_valid,
    input  cache_pkg::word_t        core_rsp_data,
    input  cache_pkg::req_tag_t     core_rsp_tag,
    input  logic                    core_rsp_ready,
    input  logic                    mem_req_valid,
    input  logic                    mem_req_rw,
    input  cache_pkg::line_addr_t   mem_req_addr,
    input  cache_pkg::line_byteen_t mem_req_byteen,
    input  cache_pkg::line_t        mem_req_data,
    input  logic                    mem_req_ready,
    input  logic                    mem_rsp_ready,
    output int                      mismatches,
    output int                      failures,
    output logic                    busy
);
    import cache_pkg::*;

    // shadow of memory as the core sees it
    word_t        shadow [256][WORDS_PER_LINE];
    logic         tag_valid [NUM_LINES];
    cache_tag_t   tag_model [NUM_LINES];

    // accepted reads, oldest first
    req_tag_t     rd_tag_q [$];
    word_t        rd_data_q [$];
    int           rd_cycle_q [$];

    // memory requests still to be seen
    logic         exp_rw_q [$];
    line_addr_t   exp_addr_q [$];
    line_byteen_t exp_byteen_q [$];
    line_t        exp_data_q [$];

    int           mismatch_cnt;
    int           failure_cnt;
    int           cycle;
    int           init_cycles;
    logic         seen_ready;
    int           pending;

    assign mismatches = mismatch_cnt;
    assign failures   = failure_cnt;
    assign busy       = (pending != 0);

    task automatic note_mismatch(input string name, input line_t expected, input line_t actual);
        $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
        mismatch_cnt = mismatch_cnt + 1;
    endtask

    task automatic flag_failure(input string what);
        $display("ERROR: %s at cycle %0d", what, cycle);
        failure_cnt = failure_cnt + 1;
    endtask

    task automatic accept_request();
        line_sel_t    idx;
        cache_tag_t   tag;
        line_byteen_t be;
        line_t        line;
        idx = core_req_addr[LINE_SEL_BITS-1:0];
        tag = core_req_addr[LINE_ADDR_BITS-1 -: CACHE_TAG_BITS];
        if (core_req_rw) begin
            be = '0;
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (core_req_byteen[b]) begin
                    shadow[core_req_addr][core_req_wsel][b*8 +: 8] = core_req_data[b*8 +: 8];
                end
                be[int'(core_req_wsel) * WORD_BYTES + b] = core_req_byteen[b];
            end
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                line[w*WORD_BITS +: WORD_BITS] = core_req_data;
            end
            // write-through leaves the tag model as it is
            exp_rw_q.push_back(1'b1);
            exp_addr_q.push_back(core_req_addr);
            exp_byteen_q.push_back(be);
            exp_data_q.push_back(line);
        end else begin
            rd_tag_q.push_back(core_req_tag);
            rd_data_q.push_back(shadow[core_req_addr][core_req_wsel]);
            rd_cycle_q.push_back(cycle);
            if (!tag_valid[idx] || tag_model[idx] != tag) begin
                // line not resident so one line read
                exp_rw_q.push_back(1'b0);
                exp_addr_q.push_back(core_req_addr);
                exp_byteen_q.push_back('0);
                exp_data_q.push_back('0);
                tag_valid[idx] = 1'b1;
                tag_model[idx] = tag;
            end
        end
    endtask

    task automatic compare_response();
        req_tag_t exp_tag;
        word_t    exp_data;
        int       acc_cycle;
        if (rd_tag_q.size() == 0) begin
            flag_failure("core response arrived with no outstanding read");
        end else begin
            exp_tag   = rd_tag_q.pop_front();
            exp_data  = rd_data_q.pop_front();
            acc_cycle = rd_cycle_q.pop_front();
            if (cycle - acc_cycle < 3) begin
                flag_failure($sformatf("response came %0d cycles after its request",
                                       cycle - acc_cycle));
            end
            if (core_rsp_tag !== exp_tag) begin
                note_mismatch("rsp_tag", line_t'(exp_tag), line_t'(core_rsp_tag));
            end
            if (core_rsp_data !== exp_data) begin
                note_mismatch("rsp_data", line_t'(exp_data), line_t'(core_rsp_data));
            end
        end
    endtask

    task automatic match_mem_request();
        logic         exp_rw;
        line_addr_t   exp_addr;
        line_byteen_t exp_be;
        line_t        exp_line;
        if (exp_rw_q.size() == 0) begin
            flag_failure("memory request appeared when none was expected");
        end else begin
            exp_rw   = exp_rw_q.pop_front();
            exp_addr = exp_addr_q.pop_front();
            exp_be   = exp_byteen_q.pop_front();
            exp_line = exp_data_q.pop_front();
            if (mem_req_rw !== exp_rw) begin
                note_mismatch("mem_rw", line_t'(exp_rw), line_t'(mem_req_rw));
            end
            if (mem_req_addr !== exp_addr) begin
                note_mismatch("mem_addr", line_t'(exp_addr), line_t'(mem_req_addr));
            end
            // read requests carry no meaningful data
            if (exp_rw && mem_req_byteen !== exp_be) begin
                note_mismatch("mem_byteen", line_t'(exp_be), line_t'(mem_req_byteen));
            end
            if (exp_rw && mem_req_data !== exp_line) begin
                note_mismatch("mem_data", exp_line, mem_req_data);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int a = 0; a < 256; a++) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    shadow[a][w] = a * 256 + w;
                end
            end
            for (int i = 0; i < NUM_LINES; i++) begin
                tag_valid[i] = 1'b0;
                tag_model[i] = '0;
            end
            rd_tag_q.delete();
            rd_data_q.delete();
            rd_cycle_q.delete();
            exp_rw_q.delete();
            exp_addr_q.delete();
            exp_byteen_q.delete();
            exp_data_q.delete();
            mismatch_cnt = 0;
            failure_cnt  = 0;
            cycle        = 0;
            init_cycles  = 0;
            seen_ready   = 1'b0;
            pending      = 0;
        end else begin
            cycle = cycle + 1;
            // init sweep keeps the bank closed
            if (!seen_ready) begin
                if (core_rsp_valid || mem_req_valid || mem_rsp_ready) begin
                    flag_failure("bank outputs active before the init sweep ended");
                end
                if (core_req_ready) begin
                    seen_ready = 1'b1;
                    if (init_cycles < NUM_LINES) begin
                        flag_failure($sformatf("core_req_ready rose after only %0d cycles",
                                               init_cycles));
                    end
                end else begin
                    init_cycles = init_cycles + 1;
                end
            end
            if (core_req_valid && core_req_ready) begin
                accept_request();
            end
            if (core_rsp_valid && core_rsp_ready) begin
                compare_response();
            end
            if (mem_req_valid && mem_req_ready) begin
                match_mem_request();
            end
            pending = rd_tag_q.size() + exp_rw_q.size();
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import cache_pkg::*;

    localparam int NUM_REQS       = 400;
    localparam int CLK_PERIOD     = 10;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 40;

    logic         clk = 1'b0;
    logic         reset;

    logic         core_req_valid;
    logic         core_req_rw;
    line_addr_t   core_req_addr;
    word_sel_t    core_req_wsel;
    byteen_t      core_req_byteen;
    word_t        core_req_data;
    req_tag_t     core_req_tag;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    req_tag_t     core_rsp_tag;
    logic         core_rsp_ready;

    logic         mem_req_valid;
    logic         mem_req_rw;
    line_addr_t   mem_req_addr;
    line_byteen_t mem_req_byteen;
    line_t        mem_req_data;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    line_t        mem_rsp_data;
    logic         mem_rsp_ready;

    int           seed;
    int           issued;
    int           mismatches;
    int           failures;
    logic         checker_busy;
    req_tag_t     next_tag;

    // memory model with at most one line read outstanding
    line_t        mem_lines [256];
    logic         fill_pending;
    int           fill_wait;
    line_addr_t   fill_addr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_bank_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    cache_checker i_checker (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_ready   (mem_rsp_ready),
        .mismatches      (mismatches),
        .failures        (failures),
        .busy            (checker_busy)
    );

    // random read or write within 32 line addresses
    task automatic next_request();
        logic [31:0] rnd;
        rnd             = $random(seed);
        core_req_rw     = (rnd[2:0] < 3'd3);
        core_req_addr   = {3'b000, rnd[8:4]};
        core_req_wsel   = rnd[10:9];
        core_req_byteen = rnd[14:11];
        core_req_tag    = next_tag;
        core_req_data   = $random(seed);
        core_req_valid  = 1'b1;
        next_tag        = next_tag + 1'b1;
    endtask

    task automatic serve_mem_request();
        logic [31:0] rnd;
        if (mem_req_rw) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (mem_req_byteen[i]) begin
                    mem_lines[mem_req_addr][i*8 +: 8] = mem_req_data[i*8 +: 8];
                end
            end
        end else begin
            // fill comes back 1 to 6 cycles later
            rnd          = $random(seed);
            fill_addr    = mem_req_addr;
            fill_wait    = int'(rnd[7:0]) % 6 + 1;
            fill_pending = 1'b1;
        end
    endtask

    task automatic print_totals();
        $display("summary: %0d requests issued, %0d mismatches, %0d other errors",
                 issued, mismatches, failures);
    endtask

    initial begin
        logic [31:0] rnd;
        logic        req_fire;
        logic        mreq_fire;
        logic        fill_fire;
        logic        finished;
        seed            = 32'hc902;
        issued          = 0;
        next_tag        = '0;
        finished        = 1'b0;
        fill_pending    = 1'b0;
        fill_wait       = 0;
        fill_addr       = '0;
        reset           = 1'b1;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b0;
        mem_req_ready   = 1'b0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_data    = '0;
        for (int a = 0; a < 256; a++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_lines[a][w*WORD_BITS +: WORD_BITS] = a * 256 + w;
            end
        end

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        while (!finished) begin
            @(posedge clk);
            req_fire  = core_req_valid && core_req_ready;
            mreq_fire = mem_req_valid && mem_req_ready;
            fill_fire = mem_rsp_valid && mem_rsp_ready;
            if (mreq_fire) begin
                serve_mem_request();
            end
            #1;
            rnd = $random(seed);
            if (req_fire) begin
                issued         = issued + 1;
                core_req_valid = 1'b0;
            end
            if (fill_fire) begin
                mem_rsp_valid = 1'b0;
            end
            if (fill_pending) begin
                if (fill_wait > 1) begin
                    fill_wait = fill_wait - 1;
                end else begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = mem_lines[fill_addr];
                    fill_pending  = 1'b0;
                end
            end
            if (!core_req_valid && issued < NUM_REQS && rnd[2:0] != 3'd0) begin
                next_request();
            end
            // ready about three cycles in four
            core_rsp_ready = rnd[3] | rnd[4];
            mem_req_ready  = rnd[5] | rnd[6];
            finished       = (issued == NUM_REQS) && !checker_busy;
        end

        // quiet tail to catch stray responses
        repeat (10) @(posedge clk);
        print_totals();
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_totals();
        $display("Verification failed");
        $finish;
    end

endmodule

/* sim.f */
hw/cache_pkg.sv
hw/tag_lookup_if.sv
hw/data_access_if.sv
hw/sync_fifo.sv
hw/tag_store.sv
hw/data_store.sv
hw/bank_ctrl.sv
hw/cache_bank_top.sv
dv/cache_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top -f sim.f -o tb_sim

if ! sim_out=$(./obj_dir/tb_sim); then
    echo "$sim_out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$sim_out"

echo "$sim_out" | grep -qx "Verification passed"
